// File: hw/isaPkg.sv
package isaPkg;

// ===============================================
// Opcode and function encodings
// ===============================================

typedef enum logic [5:0] {
	R2    = 6'd0,
	BRK   = 6'd1,
	ADDI  = 6'd4,
	SUBFI = 6'd5,
	ANDI  = 6'd8,
	ORI   = 6'd9,
	XORI  = 6'd10,
	CMPI  = 6'd11,
	CALLA = 6'd16,
	CALLR = 6'd17,
	RET   = 6'd18,
	Bcc   = 6'd20,
	FMA   = 6'd24,
	LDB   = 6'd32,
	LDBU  = 6'd33,
	LDW   = 6'd34,
	LDWU  = 6'd35,
	LDT   = 6'd36,
	STB   = 6'd40,
	STW   = 6'd41,
	STT   = 6'd42,
	CSR   = 6'd48,
	PFX   = 6'd56,
	NOP   = 6'd63
} opcodeE;

// All codes stay below 32 because the R2 word only has room for five func bits
typedef enum logic [5:0] {
	ADD   = 6'd0,
	SUB   = 6'd1,
	AND   = 6'd2,
	OR    = 6'd3,
	XOR   = 6'd4,
	SLL   = 6'd8,
	SRL   = 6'd9,
	SRA   = 6'd10,
	LDBX  = 6'd16,
	LDBUX = 6'd17,
	LDWX  = 6'd18,
	LDWUX = 6'd19,
	LDTX  = 6'd20,
	STBX  = 6'd24,
	STWX  = 6'd25,
	STTX  = 6'd26,
	R1    = 6'd31
} funcE;

// Sub-operations of R1, carried in the number part of the Rb field
typedef enum logic [5:0] {
	RTI = 6'd1,
	REX = 6'd2
} r1FuncE;

typedef enum logic [1:0] {
	CSRRD = 2'd0,
	CSRRW = 2'd1,
	CSRRC = 2'd2,
	CSRRS = 2'd3
} csrFuncE;

// ===============================================
// Instruction word overlays
// ===============================================

// Register fields are a vector flag in bit 6 over a 6-bit register number.
// Every format that names a target keeps it in bits 12:6
typedef struct packed {
	logic [25:0] payload;
	opcodeE opcode;
} anyFmtT;

typedef struct packed {
	logic [4:0] func;
	logic [6:0] Rb;
	logic [6:0] Ra;
	logic [6:0] Rt;
	opcodeE opcode;
} r2FmtT;

typedef struct packed {
	logic [11:0] imm;
	logic [6:0] Ra;
	logic [6:0] Rt;
	opcodeE opcode;
} riFmtT;

typedef struct packed {
	logic [11:0] disp;
	logic [6:0] Ra;
	logic [6:0] Rt;
	opcodeE opcode;
} lsFmtT;

typedef struct packed {
	logic [8:0] disp;
	logic [2:0] cond;
	logic [6:0] Rb;
	logic [6:0] Ra;
	opcodeE opcode;
} brFmtT;

typedef struct packed {
	logic [18:0] target;
	logic [6:0] Rt;
	opcodeE opcode;
} callFmtT;

typedef struct packed {
	logic [9:0] regno;
	csrFuncE func;
	logic [6:0] Ra;
	logic [6:0] Rt;
	opcodeE opcode;
} csrFmtT;

// The prefix also carries the vector mask selection for the next word
typedef struct packed {
	logic m;
	logic [2:0] Rm;
	logic [5:0] rsv;
	logic [15:0] imm;
	opcodeE opcode;
} pfxFmtT;

typedef union packed {
	anyFmtT any;
	r2FmtT r2;
	riFmtT ri;
	lsFmtT ls;
	brFmtT br;
	callFmtT call;
	csrFmtT csr;
	pfxFmtT pfx;
} insnU;

function automatic funcE r2Func(insnU insn);
	return funcE'({1'b0, insn.r2.func});
endfunction

endpackage

// File: hw/decodePkg.sv
package decodePkg;
	import isaPkg::*;

// ===============================================
// Register specifiers and memory sizes
// ===============================================

typedef struct packed {
	logic vec;
	logic [5:0] num;
} regSpecT;

typedef enum logic [1:0] {
	byt   = 2'd0,
	wyde  = 2'd1,
	tetra = 2'd2,
	vect  = 2'd3
} memSizeE;

// What the fetch buffer hands over each strobe
typedef struct packed {
	insnU pfx;
	insnU insn;
} fetchBufT;

// ===============================================
// Decode bus
// ===============================================

typedef struct packed {
	regSpecT Ra;
	regSpecT Rb;
	regSpecT Rc;
	regSpecT Rt;
	regSpecT Rm;
	logic [31:0] imm;
	logic hasRa;
	logic hasRb;
	logic hasRc;
	logic hasRt;
	logic hasRm;
} operandBusT;

typedef struct packed {
	logic rti;
	logic rex;
	logic brk;
	logic br;
	logic cjb;
	logic pfx;
	logic csr;
	csrFuncE csrOp;
	logic loadr;
	logic loadn;
	logic loadu;
	logic storer;
	logic storen;
	logic load;
	logic store;
	logic mem;
	memSizeE memsz;
	logic rfwr;
	logic vrfwr;
} controlBusT;

typedef struct packed {
	operandBusT opnd;
	controlBusT ctrl;
	logic isVector;
	logic needSteps;
} decodeBusT;

endpackage

// File: hw/operandDecoder.sv
`timescale 1ns/1ps

module operandDecoder import isaPkg::*, decodePkg::*; #(
	parameter int spBankBase = 44
) (
	input fetchBufT ifb,
	input logic [2:0] spSel,
	output operandBusT opnd
);

opcodeE op;
funcE fn;
logic r2Live;
logic hasPfx;
regSpecT raRaw;
regSpecT rbRaw;
regSpecT rtRaw;

assign op = ifb.insn.any.opcode;
assign fn = r2Func(ifb.insn);
assign hasPfx = ifb.pfx.any.opcode == PFX;

// R2 words with real register operands. R1 reuses Rb as a sub-op code
assign r2Live = op == R2 && fn inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SRA,
	LDBX, LDBUX, LDWX, LDWUX, LDTX, STBX, STWX, STTX};

// Scalar r31 is the stack pointer, banked per operating level
function automatic regSpecT spBank(regSpecT r, logic [2:0] sel);
	regSpecT res;
	res = r;
	if (!r.vec && r.num == 6'd31 && sel inside {[3'd1:3'd4]})
		res.num = 6'(spBankBase) + {3'b000, sel} - 6'd1;
	return res;
endfunction

always_comb begin
	// Branches put their compare operands in different bit positions
	raRaw = (op == Bcc) ? ifb.insn.br.Ra : ifb.insn.r2.Ra;
	rbRaw = (op == Bcc) ? ifb.insn.br.Rb : ifb.insn.r2.Rb;

	rtRaw = '0;
	opnd.hasRt = 1'b0;
	case (op)
	R2, FMA: begin
		if (op == FMA || r2Live) begin
			rtRaw = ifb.insn.r2.Rt;
			opnd.hasRt = 1'b1;
		end
	end
	ADDI, SUBFI, ANDI, ORI, XORI, CMPI, RET: begin
		rtRaw = ifb.insn.ri.Rt;
		opnd.hasRt = 1'b1;
	end
	LDB, LDBU, LDW, LDWU, LDT, STB, STW, STT: begin
		rtRaw = ifb.insn.ls.Rt;
		opnd.hasRt = 1'b1;
	end
	CALLA, CALLR: begin
		rtRaw = ifb.insn.call.Rt;
		opnd.hasRt = 1'b1;
	end
	CSR: begin
		rtRaw = ifb.insn.csr.Rt;
		opnd.hasRt = 1'b1;
	end
	default: ;
	endcase

	opnd.Ra = spBank(raRaw, spSel);
	opnd.Rb = spBank(rbRaw, spSel);
	opnd.Rt = spBank(rtRaw, spSel);
	// FMA accumulates into its target, so Rc reads the Rt field
	opnd.Rc = (op == FMA) ? spBank(ifb.insn.r2.Rt, spSel) : '0;
	// Mask registers live at scalar numbers 32 to 39
	opnd.Rm = {1'b0, 3'b100, ifb.pfx.pfx.Rm};

	case (op)
	ADDI, SUBFI, ANDI, ORI, XORI, CMPI, RET:
		opnd.imm = {{20{ifb.insn.ri.imm[11]}}, ifb.insn.ri.imm};
	LDB, LDBU, LDW, LDWU, LDT, STB, STW, STT:
		opnd.imm = {{20{ifb.insn.ls.disp[11]}}, ifb.insn.ls.disp};
	Bcc:
		opnd.imm = {{23{ifb.insn.br.disp[8]}}, ifb.insn.br.disp};
	CALLA, CALLR:
		opnd.imm = {{13{ifb.insn.call.target[18]}}, ifb.insn.call.target};
	CSR:
		opnd.imm = {22'd0, ifb.insn.csr.regno};
	default:
		opnd.imm = '0;
	endcase
	if (hasPfx)
		opnd.imm[31:16] = ifb.pfx.pfx.imm;

	opnd.hasRa = r2Live || op inside {ADDI, SUBFI, ANDI, ORI, XORI, CMPI, RET, CSR,
		Bcc, FMA, LDB, LDBU, LDW, LDWU, LDT, STB, STW, STT};
	opnd.hasRb = r2Live || op inside {Bcc, FMA};
	opnd.hasRc = op == FMA;
	opnd.hasRm = hasPfx && ifb.pfx.pfx.m &&
		!(op inside {Bcc, CALLA, CALLR, PFX, NOP, BRK});
end

endmodule

// File: hw/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder import isaPkg::*, decodePkg::*; (
	input fetchBufT ifb,
	output controlBusT ctrl
);

opcodeE op;
funcE fn;
logic isR2;
logic rtVec;

assign op = ifb.insn.any.opcode;
assign fn = r2Func(ifb.insn);
assign isR2 = op == R2;

// Target vector flag, shared by every format that has a target
assign rtVec = ifb.insn.r2.Rt[6];

always_comb begin
	// ===============================================
	// Operation class
	// ===============================================
	ctrl.rti = isR2 && fn == R1 && ifb.insn.r2.Rb[5:0] == RTI;
	ctrl.rex = isR2 && fn == R1 && ifb.insn.r2.Rb[5:0] == REX;
	ctrl.brk = op == BRK;
	ctrl.br = op == Bcc;
	ctrl.cjb = op inside {CALLA, CALLR};
	ctrl.pfx = op == PFX;
	ctrl.csr = op == CSR;
	ctrl.csrOp = ctrl.csr ? ifb.insn.csr.func : CSRRD;

	// Loads and stores come in register-displacement and indexed forms
	ctrl.loadr = op inside {LDB, LDBU, LDW, LDWU, LDT};
	ctrl.loadn = isR2 && fn inside {LDBX, LDBUX, LDWX, LDWUX, LDTX};
	ctrl.loadu = op inside {LDBU, LDWU} || (isR2 && fn inside {LDBUX, LDWUX});
	ctrl.storer = op inside {STB, STW, STT};
	ctrl.storen = isR2 && fn inside {STBX, STWX, STTX};
	ctrl.load = ctrl.loadr | ctrl.loadn;
	ctrl.store = ctrl.storer | ctrl.storen;
	ctrl.mem = ctrl.load | ctrl.store;

	// Base size only, the vector override is applied at the merge
	case (op)
	LDB, LDBU, STB:
		ctrl.memsz = byt;
	LDW, LDWU, STW:
		ctrl.memsz = wyde;
	R2: begin
		case (fn)
		LDBX, LDBUX, STBX:
			ctrl.memsz = byt;
		LDWX, LDWUX, STWX:
			ctrl.memsz = wyde;
		default:
			ctrl.memsz = tetra;
		endcase
	end
	default:
		ctrl.memsz = tetra;
	endcase

	// ===============================================
	// Register file write enables
	// ===============================================
	ctrl.rfwr = 1'b0;
	ctrl.vrfwr = 1'b0;
	case (op)
	R2: begin
		if (fn inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SRA,
			LDBX, LDBUX, LDWX, LDWUX, LDTX}) begin
			ctrl.rfwr = ~rtVec;
			ctrl.vrfwr = rtVec;
		end
	end
	ADDI, SUBFI, ANDI, ORI, XORI, CMPI, RET, FMA, CSR,
	LDB, LDBU, LDW, LDWU, LDT: begin
		ctrl.rfwr = ~rtVec;
		ctrl.vrfwr = rtVec;
	end
	// A call with an r0 link field does not save its return address
	CALLA, CALLR:
		ctrl.rfwr = ifb.insn.call.Rt != 7'd0;
	default: ;
	endcase
end

// Opcode and R2 function classes must never overlap a load with a store
always_comb begin
	assert (!(ctrl.load && ctrl.store))
	else $error("controlDecoder flagged load and store together");
end

endmodule

// File: hw/decodeMerge.sv
`timescale 1ns/1ps

module decodeMerge import decodePkg::*; (
	input logic clk,
	input logic rstN,
	input logic insnValid,
	input logic rz,
	input operandBusT opnd,
	input controlBusT ctrl,
	output logic decoValid,
	output decodeBusT deco
);

decodeBusT nxt;
logic vecMem;

// Any vector operand turns the access into an element-wise one
assign vecMem = (opnd.hasRa && opnd.Ra.vec) ||
	((ctrl.loadn || ctrl.storen) && opnd.hasRb && opnd.Rb.vec) ||
	(opnd.hasRt && opnd.Rt.vec);

always_comb begin
	nxt.opnd = opnd;
	nxt.ctrl = ctrl;

	// With rz set, r0 reads as zero and writes to it are dropped
	if (ctrl.rfwr && opnd.Rt == '0)
		nxt.ctrl.rfwr = ~rz;

	if (vecMem)
		nxt.ctrl.memsz = vect;

	nxt.isVector = (opnd.hasRa && opnd.Ra.vec) ||
		(opnd.hasRb && opnd.Rb.vec) ||
		(opnd.hasRc && opnd.Rc.vec) ||
		(opnd.hasRt && opnd.Rt.vec) ||
		(opnd.hasRm && opnd.Rm.vec);

	// A scalar base with a plain displacement moves the vector in one access
	nxt.needSteps = nxt.ctrl.memsz == vect &&
		!((ctrl.loadr || ctrl.storer) && !opnd.Ra.vec);
end

always_ff @(posedge clk or negedge rstN) begin
	if (!rstN) begin
		decoValid <= 1'b0;
		deco <= '0;
	end else begin
		decoValid <= insnValid;
		if (insnValid)
			deco <= nxt;
	end
end

// ===============================================
// Checks
// ===============================================

rfVrfExclusive: assert property (@(posedge clk) disable iff (!rstN)
	decoValid |-> !(deco.ctrl.rfwr && deco.ctrl.vrfwr));

validBackToBack: assert property (@(posedge clk) disable iff (!rstN)
	(decoValid && $past(decoValid)) |-> ($past(insnValid) && $past(insnValid, 2)));

endmodule

// File: hw/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import decodePkg::*; #(
	parameter int spBankBase = 44
) (
	input logic clk,
	input logic rstN,
	input logic insnValid,
	input fetchBufT ifb,
	input logic [2:0] spSel,
	input logic rz,
	output logic decoValid,
	output decodeBusT deco
);

operandBusT opnd;
controlBusT ctrl;

// Both halves decode the same fetch buffer in parallel
operandDecoder #(
	.spBankBase(spBankBase)
) operandDec (
	.ifb(ifb),
	.spSel(spSel),
	.opnd(opnd)
);

controlDecoder controlDec (
	.ifb(ifb),
	.ctrl(ctrl)
);

decodeMerge merge (
	.clk(clk),
	.rstN(rstN),
	.insnValid(insnValid),
	.rz(rz),
	.opnd(opnd),
	.ctrl(ctrl),
	.decoValid(decoValid),
	.deco(deco)
);

endmodule

// File: verif/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb import decodePkg::*; ();

// One line of the cases file, stimulus first and expected decode after it
typedef struct packed {
	logic [31:0] pfxWord;
	logic [31:0] insnWord;
	logic [2:0] spSel;
	logic rz;
	logic [6:0] expRa;
	logic [6:0] expRb;
	logic [6:0] expRt;
	logic [31:0] expImm;
	logic [1:0] expMemsz;
	logic expRfwr;
	logic expVrfwr;
	logic expLoad;
	logic expStore;
	logic expIsVector;
	logic expNeedSteps;
} caseT;

logic clk;
logic rstN;
logic insnValid;
fetchBufT ifb;
logic [2:0] spSel;
logic rz;
logic decoValid;
decodeBusT deco;

caseT testCases[$];
int pending;
bit loaded;

decodeStage #(
	.spBankBase(44)
) uut (
	.clk(clk),
	.rstN(rstN),
	.insnValid(insnValid),
	.ifb(ifb),
	.spSel(spSel),
	.rz(rz),
	.decoValid(decoValid),
	.deco(deco)
);

initial clk = 1'b0;
always #50 clk = ~clk;

// ================================================
// Helpers
// ================================================

task automatic failRun(input string msg);
	$display("%s", msg);
	$display("=== FAIL ===");
	$fatal(1, "decode stage test stopped");
endtask

task automatic compareField(input string name, input logic [31:0] got, input logic [31:0] expVal);
	assert (got === expVal)
	else failRun($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, expVal, got));
endtask

task automatic loadCases();
	int fd;
	int code;
	string line;
	logic [31:0] fld [15];
	caseT c;
	fd = $fopen("verif/decodeCases.txt", "r");
	if (fd == 0)
		failRun("cannot open the cases file verif/decodeCases.txt");
	while (!$feof(fd)) begin
		line = "";
		code = $fgets(line, fd);
		// Blank lines and lines starting with # carry no case
		if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
			code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
				fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14]);
			if (code != 15)
				failRun($sformatf("malformed line in the cases file: %s", line));
			c.pfxWord = fld[0];
			c.insnWord = fld[1];
			c.spSel = fld[2][2:0];
			c.rz = fld[3][0];
			c.expRa = fld[4][6:0];
			c.expRb = fld[5][6:0];
			c.expRt = fld[6][6:0];
			c.expImm = fld[7];
			c.expMemsz = fld[8][1:0];
			c.expRfwr = fld[9][0];
			c.expVrfwr = fld[10][0];
			c.expLoad = fld[11][0];
			c.expStore = fld[12][0];
			c.expIsVector = fld[13][0];
			c.expNeedSteps = fld[14][0];
			testCases.push_back(c);
		end
	end
	$fclose(fd);
	if (testCases.size() == 0)
		failRun("the cases file holds no test cases");
endtask

task automatic checkCase(input int idx);
	caseT c;
	c = testCases[idx];
	compareField("decoValid", {31'd0, decoValid}, 32'd1);
	compareField("Ra", {25'd0, deco.opnd.Ra}, {25'd0, c.expRa});
	compareField("Rb", {25'd0, deco.opnd.Rb}, {25'd0, c.expRb});
	compareField("Rt", {25'd0, deco.opnd.Rt}, {25'd0, c.expRt});
	compareField("imm", deco.opnd.imm, c.expImm);
	compareField("memsz", {30'd0, deco.ctrl.memsz}, {30'd0, c.expMemsz});
	compareField("rfwr", {31'd0, deco.ctrl.rfwr}, {31'd0, c.expRfwr});
	compareField("vrfwr", {31'd0, deco.ctrl.vrfwr}, {31'd0, c.expVrfwr});
	compareField("load", {31'd0, deco.ctrl.load}, {31'd0, c.expLoad});
	compareField("store", {31'd0, deco.ctrl.store}, {31'd0, c.expStore});
	compareField("isVector", {31'd0, deco.isVector}, {31'd0, c.expIsVector});
	compareField("needSteps", {31'd0, deco.needSteps}, {31'd0, c.expNeedSteps});
endtask

// Drives one cycle (a case index, or -1 for idle) and checks the strobe of the cycle before
task automatic runCycle(input int drvIdx);
	@(posedge clk);
	if (drvIdx >= 0) begin
		insnValid <= 1'b1;
		ifb <= {testCases[drvIdx].pfxWord, testCases[drvIdx].insnWord};
		spSel <= testCases[drvIdx].spSel;
		rz <= testCases[drvIdx].rz;
	end else begin
		insnValid <= 1'b0;
	end
	@(negedge clk);
	if (pending >= 0)
		checkCase(pending);
	else
		compareField("decoValid", {31'd0, decoValid}, 32'd0);
	pending = drvIdx;
endtask

// ================================================
// Main sequence
// ================================================

initial begin
	rstN = 1'b0;
	insnValid = 1'b0;
	ifb = '0;
	spSel = 3'd0;
	rz = 1'b0;
	pending = -1;
	loadCases();
	loaded = 1'b1;

	repeat (4) @(posedge clk);
	@(negedge clk);
	compareField("decoValid in reset", {31'd0, decoValid}, 32'd0);
	assert (deco == '0)
	else failRun($sformatf("mismatch at %0t: deco is not zero during reset", $time));
	@(posedge clk);
	rstN <= 1'b1;

	// Mostly back-to-back strobes, with two idle cycles after every fourth case
	for (int i = 0; i < testCases.size(); i++) begin
		runCycle(i);
		if (i % 4 == 3) begin
			runCycle(-1);
			runCycle(-1);
		end
	end
	runCycle(-1);
	runCycle(-1);

	$display("=== PASS ===");
	$finish;
end

// Three cycles per case leaves ample room for the idle gaps
initial begin
	wait (loaded);
	repeat (testCases.size() * 3 + 20) @(posedge clk);
	failRun("watchdog timeout, the decode stage test did not finish in time");
end

endmodule

// File: verif/decodeCases.txt
# pfx insn spSel rz | expected Ra Rb Rt imm memsz rfwr vrfwr load store isVector needSteps
# All columns hex; memsz 0 byte, 1 wyde, 2 tetra, 3 vect
00000000 002020c0 0 0 01 02 03 00000000 2 1 0 0 0 0 0
00000000 00203140 0 0 01 02 45 00000000 3 0 1 0 0 1 1
00000000 0828e100 0 0 47 02 04 00000000 3 1 0 0 0 1 1
00000000 24902180 0 0 01 49 06 00000000 2 1 0 0 0 1 0
00000000 ffc3e144 0 0 1f 7c 05 fffffffc 2 1 0 0 0 0 0
00000000 ffc3e144 1 0 2c 7c 05 fffffffc 2 1 0 0 0 0 0
00000000 0103e7c4 4 0 2f 10 2f 00000010 2 1 0 0 0 0 0
00000000 0103e7c4 5 0 1f 10 1f 00000010 2 1 0 0 0 0 0
00000000 01f3e080 2 0 2d 2d 02 00000000 2 1 0 0 0 0 0
00000000 01f3e080 3 0 2e 2e 02 00000000 2 1 0 0 0 0 0
00000000 01f3e080 6 0 1f 1f 02 00000000 2 1 0 0 0 0 0
00000000 01fbe080 1 0 5f 2c 02 00000000 3 1 0 0 0 1 1
00000000 ffc3e144 7 0 1f 7c 05 fffffffc 2 1 0 0 0 0 0
00000000 7ff00049 0 0 00 7f 01 000007ff 2 1 0 0 0 0 0
00000000 ff1080d4 0 0 03 04 00 fffffffe 2 0 0 0 0 0 0
00000000 80002050 0 0 01 00 01 fffc0001 2 1 0 0 0 0 0
00000000 00020011 0 1 10 00 00 00000010 2 0 0 0 0 0 0
00048d38 00502144 0 0 01 05 05 12340005 2 1 0 0 0 0 0
002af378 fff02144 0 0 01 7f 05 abcdffff 2 1 0 0 0 0 0
00000000 008060a0 0 0 03 08 02 00000008 0 1 0 1 0 0 0
00000000 ff8060a3 0 0 03 78 02 fffffff8 1 1 0 1 0 0 0
00000000 00007124 0 0 03 00 44 00000000 3 0 1 1 0 1 0
00000000 00087124 0 0 43 00 44 00000000 3 0 1 1 0 1 1
00000000 0040c168 0 0 06 04 05 00000004 0 0 0 0 1 0 0
00000000 0040d16a 0 0 06 04 45 00000004 3 0 0 0 1 1 0
00000000 80406080 0 0 03 04 02 00000000 0 1 0 1 0 0 0
00000000 90406080 0 0 03 04 02 00000000 1 1 0 1 0 0 0
00000000 a4406080 0 0 03 44 02 00000000 3 1 0 1 0 1 1
00000000 c8406080 0 0 03 04 02 00000000 1 0 0 0 1 0 0
00000000 c0406080 0 0 03 04 02 00000000 0 0 0 0 1 0 0
00000000 00202000 0 1 01 02 00 00000000 2 0 0 0 0 0 0
00000000 00202000 0 0 01 02 00 00000000 2 1 0 0 0 0 0
00000000 00203000 0 1 01 02 40 00000000 3 0 1 0 0 1 1
00000000 0000003f 0 0 00 00 00 00000000 2 0 0 0 0 0 0

// File: flist.f
hw/isaPkg.sv
hw/decodePkg.sv
hw/operandDecoder.sv
hw/controlDecoder.sv
hw/decodeMerge.sv
hw/decodeStage.sv
verif/decodeStageTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps -f flist.f \
	--top-module decodeStageTb -o simv &&
./obj_dir/simv || exit 1
